/* verilog/axi_burst_defines.svh */
// Bus widths, memory depth and burst limit for the AXI4 burst subsystem
// Size and index widths are derived from the base values

`ifndef AXI_BURST_DEFINES_SVH
`define AXI_BURST_DEFINES_SVH

`define AXI_ADDR_W    16
`define AXI_DATA_W    32
`define AXI_ID_W      4
`define AXI_MAX_BEATS 16
`define MEM_WORDS     256

`define AXI_BYTES     (`AXI_DATA_W / 8)
`define AXI_SIZE      ($clog2(`AXI_BYTES))
`define AXI_LEN_W     ($clog2(`AXI_MAX_BEATS))
`define MEM_IDX_W     ($clog2(`MEM_WORDS))

`endif

/* verilog/axi_burst_pkg.sv */
// Shared types of the AXI4 burst subsystem
// Opcode and response enums, engine and target FSM states, completion record

`default_nettype none
`include "axi_burst_defines.svh"

package axi_burst_pkg;

	typedef enum logic {
		OP_WRITE = 1'b0,
		OP_READ  = 1'b1
	} burst_op_e;

	// Ordered so that a larger code is a worse response
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} axi_resp_e;

	typedef struct packed {
		burst_op_e             op;
		logic [`AXI_ID_W-1:0]  id;
		axi_resp_e             resp;
	} completion_t;

	typedef enum logic [2:0] {
		WR_IDLE, WR_ADDR, WR_DATA, WR_RESP, WR_DONE
	} wr_state_e;

	typedef enum logic [1:0] {
		RD_IDLE, RD_ADDR, RD_DATA, RD_DONE
	} rd_state_e;

	typedef enum logic [1:0] {
		T_IDLE, T_BEAT, T_RESP
	} tgt_state_e;

endpackage

`default_nettype wire

/* verilog/axi4_bus.sv */
// AXI4 bus interface, INCR bursts with full-width strobes only
// Modports for the write master, the read master and the slave

`default_nettype none
`include "axi_burst_defines.svh"

interface axi4_bus;

	logic                       awvalid;
	logic                       awready;
	logic [`AXI_ADDR_W-1:0]     awaddr;
	logic [`AXI_ID_W-1:0]       awid;
	logic [`AXI_LEN_W-1:0]      awlen;

	logic                       wvalid;
	logic                       wready;
	logic [`AXI_DATA_W-1:0]     wdata;
	logic                       wlast;

	logic                       bvalid;
	logic                       bready;
	logic [`AXI_ID_W-1:0]       bid;
	axi_burst_pkg::axi_resp_e   bresp;

	logic                       arvalid;
	logic                       arready;
	logic [`AXI_ADDR_W-1:0]     araddr;
	logic [`AXI_ID_W-1:0]       arid;
	logic [`AXI_LEN_W-1:0]      arlen;

	logic                       rvalid;
	logic                       rready;
	logic [`AXI_DATA_W-1:0]     rdata;
	logic [`AXI_ID_W-1:0]       rid;
	axi_burst_pkg::axi_resp_e   rresp;
	logic                       rlast;

	modport wr_master (
		output awvalid, awaddr, awid, awlen, wvalid, wdata, wlast, bready,
		input  awready, wready, bvalid, bid, bresp
	);

	modport rd_master (
		output arvalid, araddr, arid, arlen, rready,
		input  arready, rvalid, rdata, rid, rresp, rlast
	);

	modport slave (
		input  awvalid, awaddr, awid, awlen, wvalid, wdata, wlast, bready,
		input  arvalid, araddr, arid, arlen, rready,
		output awready, wready, bvalid, bid, bresp,
		output arready, rvalid, rdata, rid, rresp, rlast
	);

endinterface

`default_nettype wire

/* verilog/axi_write_engine.sv */
// AXI4 write burst engine
// Latches one command, issues AW, streams W beats from the data input,
// collects B and holds the completion until the merger takes it

`default_nettype none
`include "axi_burst_defines.svh"

module axi_write_engine (
	input  logic                        clk,
	input  logic                        rstn,
	input  logic                        cmd_valid,
	output logic                        cmd_ready,
	input  logic [`AXI_ADDR_W-1:0]      cmd_addr,
	input  logic [`AXI_ID_W-1:0]        cmd_id,
	input  logic [`AXI_LEN_W-1:0]       cmd_len,
	input  logic                        wdat_valid,
	output logic                        wdat_ready,
	input  logic [`AXI_DATA_W-1:0]      wdat,
	axi4_bus.wr_master                  bus,
	output logic                        done_valid,
	input  logic                        done_ready,
	output axi_burst_pkg::completion_t  done
);

	axi_burst_pkg::wr_state_e   state;
	logic [`AXI_ADDR_W-1:0]     addr_r;
	logic [`AXI_ID_W-1:0]       id_r;
	logic [`AXI_LEN_W-1:0]      len_r;
	logic [`AXI_LEN_W-1:0]      beat;

	assign cmd_ready = (state == axi_burst_pkg::WR_IDLE);

	assign bus.awvalid = (state == axi_burst_pkg::WR_ADDR);
	assign bus.awaddr  = addr_r;
	assign bus.awid    = id_r;
	assign bus.awlen   = len_r;

	// W beats pass straight through from the data stream
	assign bus.wvalid = (state == axi_burst_pkg::WR_DATA) && wdat_valid;
	assign bus.wdata  = wdat;
	assign bus.wlast  = (beat == len_r);
	assign wdat_ready = (state == axi_burst_pkg::WR_DATA) && bus.wready;

	assign bus.bready = (state == axi_burst_pkg::WR_RESP);
	assign done_valid = (state == axi_burst_pkg::WR_DONE);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= axi_burst_pkg::WR_IDLE;
		end else begin
			case (state)
				axi_burst_pkg::WR_IDLE: begin
					if (cmd_valid) begin
						addr_r <= cmd_addr;
						id_r   <= cmd_id;
						len_r  <= cmd_len;
						beat   <= '0;
						state  <= axi_burst_pkg::WR_ADDR;
					end
				end
				axi_burst_pkg::WR_ADDR: begin
					if (bus.awready)
						state <= axi_burst_pkg::WR_DATA;
				end
				axi_burst_pkg::WR_DATA: begin
					if (bus.wvalid && bus.wready) begin
						if (bus.wlast)
							state <= axi_burst_pkg::WR_RESP;
						else
							beat <= beat + 1'b1;
					end
				end
				axi_burst_pkg::WR_RESP: begin
					if (bus.bvalid) begin
						done.op   <= axi_burst_pkg::OP_WRITE;
						done.id   <= bus.bid;
						done.resp <= bus.bresp;
						state     <= axi_burst_pkg::WR_DONE;
					end
				end
				axi_burst_pkg::WR_DONE: begin
					// Stay here until the merger has room, new commands wait
					if (done_ready)
						state <= axi_burst_pkg::WR_IDLE;
				end
				default: state <= axi_burst_pkg::WR_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/axi_read_engine.sv */
// AXI4 read burst engine
// Issues AR, forwards R beats under back-pressure and keeps the worst
// response of the burst, with a beat count check against rlast

`default_nettype none
`include "axi_burst_defines.svh"

module axi_read_engine (
	input  logic                        clk,
	input  logic                        rstn,
	input  logic                        cmd_valid,
	output logic                        cmd_ready,
	input  logic [`AXI_ADDR_W-1:0]      cmd_addr,
	input  logic [`AXI_ID_W-1:0]        cmd_id,
	input  logic [`AXI_LEN_W-1:0]       cmd_len,
	output logic                        rdat_valid,
	input  logic                        rdat_ready,
	output logic [`AXI_DATA_W-1:0]      rdat,
	output logic                        rdat_last,
	axi4_bus.rd_master                  bus,
	output logic                        done_valid,
	input  logic                        done_ready,
	output axi_burst_pkg::completion_t  done
);

	axi_burst_pkg::rd_state_e   state;
	logic [`AXI_ADDR_W-1:0]     addr_r;
	logic [`AXI_ID_W-1:0]       id_r;
	logic [`AXI_LEN_W-1:0]      len_r;
	logic [`AXI_LEN_W-1:0]      beat;
	axi_burst_pkg::axi_resp_e   beat_resp;
	axi_burst_pkg::axi_resp_e   worst_next;

	assign cmd_ready = (state == axi_burst_pkg::RD_IDLE);

	assign bus.arvalid = (state == axi_burst_pkg::RD_ADDR);
	assign bus.araddr  = addr_r;
	assign bus.arid    = id_r;
	assign bus.arlen   = len_r;

	// A stalled consumer stalls the bus
	assign bus.rready = (state == axi_burst_pkg::RD_DATA) && rdat_ready;
	assign rdat_valid = (state == axi_burst_pkg::RD_DATA) && bus.rvalid;
	assign rdat       = bus.rdata;
	assign rdat_last  = bus.rlast;

	assign done_valid = (state == axi_burst_pkg::RD_DONE);

	// rlast on the wrong beat counts as a slave error
	always_comb begin
		beat_resp = bus.rresp;
		if ((bus.rlast != (beat == len_r)) && (beat_resp < axi_burst_pkg::SLVERR))
			beat_resp = axi_burst_pkg::SLVERR;
		worst_next = (beat_resp > done.resp) ? beat_resp : done.resp;
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= axi_burst_pkg::RD_IDLE;
		end else begin
			case (state)
				axi_burst_pkg::RD_IDLE: begin
					if (cmd_valid) begin
						addr_r    <= cmd_addr;
						id_r      <= cmd_id;
						len_r     <= cmd_len;
						beat      <= '0;
						done.resp <= axi_burst_pkg::OKAY;
						state     <= axi_burst_pkg::RD_ADDR;
					end
				end
				axi_burst_pkg::RD_ADDR: begin
					if (bus.arready)
						state <= axi_burst_pkg::RD_DATA;
				end
				axi_burst_pkg::RD_DATA: begin
					if (bus.rvalid && bus.rready) begin
						done.resp <= worst_next;
						beat      <= beat + 1'b1;
						if (bus.rlast) begin
							done.op <= axi_burst_pkg::OP_READ;
							done.id <= bus.rid;
							state   <= axi_burst_pkg::RD_DONE;
						end
					end
				end
				axi_burst_pkg::RD_DONE: begin
					if (done_ready)
						state <= axi_burst_pkg::RD_IDLE;
				end
				default: state <= axi_burst_pkg::RD_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/completion_merge.sv */
// Completion merger
// One holding slot per engine and an output register, round-robin
// between the slots when both are full, write first after reset

`default_nettype none

module completion_merge (
	input  logic                        clk,
	input  logic                        rstn,
	input  logic                        wr_valid,
	output logic                        wr_ready,
	input  axi_burst_pkg::completion_t  wr_done,
	input  logic                        rd_valid,
	output logic                        rd_ready,
	input  axi_burst_pkg::completion_t  rd_done,
	output logic                        out_valid,
	input  logic                        out_ready,
	output axi_burst_pkg::completion_t  out_done
);

	logic                        wr_full;
	logic                        rd_full;
	axi_burst_pkg::completion_t  wr_slot;
	axi_burst_pkg::completion_t  rd_slot;
	logic                        prefer_rd;
	logic                        out_free;
	logic                        pick_wr;
	logic                        pick_rd;

	assign wr_ready = !wr_full;
	assign rd_ready = !rd_full;

	assign out_free = !out_valid || out_ready;
	assign pick_wr  = out_free && wr_full && (!rd_full || !prefer_rd);
	assign pick_rd  = out_free && rd_full && !pick_wr;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			wr_full   <= 1'b0;
			rd_full   <= 1'b0;
			out_valid <= 1'b0;
			prefer_rd <= 1'b0;
		end else begin
			// A slot only fills when empty and only drains when full
			if (wr_valid && wr_ready) begin
				wr_full <= 1'b1;
				wr_slot <= wr_done;
			end
			if (rd_valid && rd_ready) begin
				rd_full <= 1'b1;
				rd_slot <= rd_done;
			end

			if (pick_wr) begin
				out_done  <= wr_slot;
				wr_full   <= 1'b0;
				prefer_rd <= 1'b1;
			end else if (pick_rd) begin
				out_done  <= rd_slot;
				rd_full   <= 1'b0;
				prefer_rd <= 1'b0;
			end

			if (pick_wr || pick_rd)
				out_valid <= 1'b1;
			else if (out_ready)
				out_valid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* verilog/axi4_mem_target.sv */
// AXI4 memory target
// Word memory with independent write and read FSMs, INCR addressing,
// SLVERR for beats beyond the memory

`default_nettype none
`include "axi_burst_defines.svh"

module axi4_mem_target (
	input  logic    clk,
	input  logic    rstn,
	axi4_bus.slave  bus
);

	logic [`AXI_DATA_W-1:0]     mem [`MEM_WORDS];

	axi_burst_pkg::tgt_state_e  wstate;
	logic [`AXI_ADDR_W-1:0]     waddr;
	logic [`AXI_ID_W-1:0]       wid;
	logic [`AXI_LEN_W-1:0]      wlen;
	logic [`AXI_LEN_W-1:0]      wcnt;
	logic                       werr;
	logic                       wr_beat;

	axi_burst_pkg::tgt_state_e  rstate;
	logic [`AXI_ADDR_W-1:0]     raddr;
	logic [`AXI_ADDR_W-1:0]     raddr_next;
	logic [`AXI_ID_W-1:0]       rid_r;
	logic [`AXI_LEN_W-1:0]      rlen;
	logic [`AXI_LEN_W-1:0]      rcnt;
	logic                       rd_load;

	function automatic logic in_range(input logic [`AXI_ADDR_W-1:0] a);
		return a < (`MEM_WORDS * `AXI_BYTES);
	endfunction

	assign bus.awready = (wstate == axi_burst_pkg::T_IDLE);
	assign bus.wready  = (wstate == axi_burst_pkg::T_BEAT);
	assign bus.bvalid  = (wstate == axi_burst_pkg::T_RESP);
	assign bus.bid     = wid;
	assign bus.bresp   = werr ? axi_burst_pkg::SLVERR : axi_burst_pkg::OKAY;
	assign wr_beat     = bus.wvalid && bus.wready;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			wstate <= axi_burst_pkg::T_IDLE;
		end else begin
			case (wstate)
				axi_burst_pkg::T_IDLE: begin
					if (bus.awvalid) begin
						waddr  <= bus.awaddr;
						wid    <= bus.awid;
						wlen   <= bus.awlen;
						wcnt   <= '0;
						werr   <= 1'b0;
						wstate <= axi_burst_pkg::T_BEAT;
					end
				end
				axi_burst_pkg::T_BEAT: begin
					if (wr_beat) begin
						// Dropped beats and a misplaced wlast both fail the burst
						if (!in_range(waddr) || (bus.wlast != (wcnt == wlen)))
							werr <= 1'b1;
						waddr <= waddr + `AXI_BYTES;
						wcnt  <= wcnt + 1'b1;
						if (wcnt == wlen)
							wstate <= axi_burst_pkg::T_RESP;
					end
				end
				axi_burst_pkg::T_RESP: begin
					if (bus.bready)
						wstate <= axi_burst_pkg::T_IDLE;
				end
				default: wstate <= axi_burst_pkg::T_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wr_beat && in_range(waddr))
			mem[waddr[`AXI_SIZE +: `MEM_IDX_W]] <= bus.wdata;
	end

	assign bus.arready = (rstate == axi_burst_pkg::T_IDLE);
	assign bus.rvalid  = (rstate == axi_burst_pkg::T_BEAT);
	assign bus.rid     = rid_r;
	assign bus.rlast   = (rcnt == rlen);

	// Next beat is fetched ahead so that rdata holds while the master stalls
	assign raddr_next = (rstate == axi_burst_pkg::T_IDLE) ? bus.araddr : raddr + `AXI_BYTES;
	assign rd_load    = (bus.arvalid && bus.arready) ||
			(bus.rvalid && bus.rready && !bus.rlast);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			rstate <= axi_burst_pkg::T_IDLE;
		end else begin
			case (rstate)
				axi_burst_pkg::T_IDLE: begin
					if (bus.arvalid) begin
						rid_r  <= bus.arid;
						rlen   <= bus.arlen;
						rcnt   <= '0;
						rstate <= axi_burst_pkg::T_BEAT;
					end
				end
				axi_burst_pkg::T_BEAT: begin
					if (bus.rready) begin
						rcnt <= rcnt + 1'b1;
						if (bus.rlast)
							rstate <= axi_burst_pkg::T_IDLE;
					end
				end
				default: rstate <= axi_burst_pkg::T_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rd_load) begin
			raddr <= raddr_next;
			if (in_range(raddr_next)) begin
				bus.rdata <= mem[raddr_next[`AXI_SIZE +: `MEM_IDX_W]];
				bus.rresp <= axi_burst_pkg::OKAY;
			end else begin
				bus.rdata <= '0;
				bus.rresp <= axi_burst_pkg::SLVERR;
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/axi_burst_top.sv */
// AXI4 burst subsystem top level
// Write and read engines, completion merger and memory target on one bus

`default_nettype none
`include "axi_burst_defines.svh"

module axi_burst_top (
	input  logic                        clk,
	input  logic                        rstn,
	input  logic                        wr_cmd_valid,
	output logic                        wr_cmd_ready,
	input  logic [`AXI_ADDR_W-1:0]      wr_cmd_addr,
	input  logic [`AXI_ID_W-1:0]        wr_cmd_id,
	input  logic [`AXI_LEN_W-1:0]       wr_cmd_len,
	input  logic                        wdat_valid,
	output logic                        wdat_ready,
	input  logic [`AXI_DATA_W-1:0]      wdat,
	input  logic                        rd_cmd_valid,
	output logic                        rd_cmd_ready,
	input  logic [`AXI_ADDR_W-1:0]      rd_cmd_addr,
	input  logic [`AXI_ID_W-1:0]        rd_cmd_id,
	input  logic [`AXI_LEN_W-1:0]       rd_cmd_len,
	output logic                        rdat_valid,
	input  logic                        rdat_ready,
	output logic [`AXI_DATA_W-1:0]      rdat,
	output logic                        rdat_last,
	output logic                        done_valid,
	input  logic                        done_ready,
	output axi_burst_pkg::burst_op_e    done_op,
	output logic [`AXI_ID_W-1:0]        done_id,
	output axi_burst_pkg::axi_resp_e    done_resp
);

	axi_burst_pkg::completion_t  wr_done;
	axi_burst_pkg::completion_t  rd_done;
	axi_burst_pkg::completion_t  done;
	logic                        wr_done_valid;
	logic                        wr_done_ready;
	logic                        rd_done_valid;
	logic                        rd_done_ready;

	axi4_bus bus ();

	axi_write_engine u_wr (
		.clk        (clk),
		.rstn       (rstn),
		.cmd_valid  (wr_cmd_valid),
		.cmd_ready  (wr_cmd_ready),
		.cmd_addr   (wr_cmd_addr),
		.cmd_id     (wr_cmd_id),
		.cmd_len    (wr_cmd_len),
		.wdat_valid (wdat_valid),
		.wdat_ready (wdat_ready),
		.wdat       (wdat),
		.bus        (bus.wr_master),
		.done_valid (wr_done_valid),
		.done_ready (wr_done_ready),
		.done       (wr_done)
	);

	axi_read_engine u_rd (
		.clk        (clk),
		.rstn       (rstn),
		.cmd_valid  (rd_cmd_valid),
		.cmd_ready  (rd_cmd_ready),
		.cmd_addr   (rd_cmd_addr),
		.cmd_id     (rd_cmd_id),
		.cmd_len    (rd_cmd_len),
		.rdat_valid (rdat_valid),
		.rdat_ready (rdat_ready),
		.rdat       (rdat),
		.rdat_last  (rdat_last),
		.bus        (bus.rd_master),
		.done_valid (rd_done_valid),
		.done_ready (rd_done_ready),
		.done       (rd_done)
	);

	completion_merge u_merge (
		.clk       (clk),
		.rstn      (rstn),
		.wr_valid  (wr_done_valid),
		.wr_ready  (wr_done_ready),
		.wr_done   (wr_done),
		.rd_valid  (rd_done_valid),
		.rd_ready  (rd_done_ready),
		.rd_done   (rd_done),
		.out_valid (done_valid),
		.out_ready (done_ready),
		.out_done  (done)
	);

	axi4_mem_target u_mem (
		.clk  (clk),
		.rstn (rstn),
		.bus  (bus.slave)
	);

	assign done_op   = done.op;
	assign done_id   = done.id;
	assign done_resp = done.resp;

endmodule

`default_nettype wire

/* verif/axi_burst_asserts.sv */
// Protocol assertions for the AXI4 burst top level
// Completion and read-data stability under back-pressure, state after reset

`default_nettype none
`include "axi_burst_defines.svh"

module axi_burst_asserts (
	input logic                      clk,
	input logic                      rstn,
	input logic                      wr_cmd_ready,
	input logic                      rd_cmd_ready,
	input logic                      rdat_valid,
	input logic                      rdat_ready,
	input logic [`AXI_DATA_W-1:0]    rdat,
	input logic                      done_valid,
	input logic                      done_ready,
	input axi_burst_pkg::burst_op_e  done_op,
	input logic [`AXI_ID_W-1:0]      done_id,
	input axi_burst_pkg::axi_resp_e  done_resp
);

	done_hold: assert property (@(posedge clk) disable iff (!rstn)
		done_valid && !done_ready |=> done_valid && $stable(done_op) &&
			$stable(done_id) && $stable(done_resp))
		else $error("completion dropped or changed before done_ready");

	rdat_hold: assert property (@(posedge clk) disable iff (!rstn)
		rdat_valid && !rdat_ready |=> rdat_valid && $stable(rdat))
		else $error("read data dropped or changed while stalled");

	reset_state: assert property (@(posedge clk)
		$rose(rstn) |-> wr_cmd_ready && rd_cmd_ready && !done_valid)
		else $error("command readys or done_valid wrong after reset");

endmodule

bind axi_burst_top axi_burst_asserts u_asserts (
	.clk          (clk),
	.rstn         (rstn),
	.wr_cmd_ready (wr_cmd_ready),
	.rd_cmd_ready (rd_cmd_ready),
	.rdat_valid   (rdat_valid),
	.rdat_ready   (rdat_ready),
	.rdat         (rdat),
	.done_valid   (done_valid),
	.done_ready   (done_ready),
	.done_op      (done_op),
	.done_id      (done_id),
	.done_resp    (done_resp)
);

`default_nettype wire

/* verif/axi_burst_tb.sv */
// Testbench for the AXI4 burst subsystem
// Reads burst commands from the tests file, streams write data, models the memory,
// checks read data, rdat_last and every completion against the expected set

`default_nettype none
`include "axi_burst_defines.svh"

module axi_burst_tb;

	localparam int MAX_TESTS = 32;
	localparam int DRIVE_DLY = 10;
	localparam int MEM_BYTES = `MEM_WORDS * `AXI_BYTES;

	logic                        clk;
	logic                        rstn;
	logic                        wr_cmd_valid;
	logic                        wr_cmd_ready;
	logic [`AXI_ADDR_W-1:0]      wr_cmd_addr;
	logic [`AXI_ID_W-1:0]        wr_cmd_id;
	logic [`AXI_LEN_W-1:0]       wr_cmd_len;
	logic                        wdat_valid;
	logic                        wdat_ready;
	logic [`AXI_DATA_W-1:0]      wdat;
	logic                        rd_cmd_valid;
	logic                        rd_cmd_ready;
	logic [`AXI_ADDR_W-1:0]      rd_cmd_addr;
	logic [`AXI_ID_W-1:0]        rd_cmd_id;
	logic [`AXI_LEN_W-1:0]       rd_cmd_len;
	logic                        rdat_valid;
	logic                        rdat_ready;
	logic [`AXI_DATA_W-1:0]      rdat;
	logic                        rdat_last;
	logic                        done_valid;
	logic                        done_ready;
	axi_burst_pkg::burst_op_e    done_op;
	logic [`AXI_ID_W-1:0]        done_id;
	axi_burst_pkg::axi_resp_e    done_resp;

	logic [15:0]                 test_vec [5*MAX_TESTS];
	logic [`AXI_DATA_W-1:0]      model [`MEM_WORDS];
	logic [31:0]                 rng_data;
	logic [31:0]                 rng_bp;
	axi_burst_pkg::completion_t  exp_q [$];
	int                          exp_test_q [$];
	int                          test_err [MAX_TESTS];
	int                          errors;
	int                          checks;
	int                          done_seen;
	int                          cycles;
	int                          cycle_limit;

	axi_burst_top uut (
		.clk          (clk),
		.rstn         (rstn),
		.wr_cmd_valid (wr_cmd_valid),
		.wr_cmd_ready (wr_cmd_ready),
		.wr_cmd_addr  (wr_cmd_addr),
		.wr_cmd_id    (wr_cmd_id),
		.wr_cmd_len   (wr_cmd_len),
		.wdat_valid   (wdat_valid),
		.wdat_ready   (wdat_ready),
		.wdat         (wdat),
		.rd_cmd_valid (rd_cmd_valid),
		.rd_cmd_ready (rd_cmd_ready),
		.rd_cmd_addr  (rd_cmd_addr),
		.rd_cmd_id    (rd_cmd_id),
		.rd_cmd_len   (rd_cmd_len),
		.rdat_valid   (rdat_valid),
		.rdat_ready   (rdat_ready),
		.rdat         (rdat),
		.rdat_last    (rdat_last),
		.done_valid   (done_valid),
		.done_ready   (done_ready),
		.done_op      (done_op),
		.done_id      (done_id),
		.done_resp    (done_resp)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic note_error(input int t);
		errors++;
		test_err[t]++;
	endtask

	task automatic check_word(input int t, input int beat,
			input logic [`AXI_DATA_W-1:0] got, input logic [`AXI_DATA_W-1:0] want);
		checks++;
		if (got !== want) begin
			$display("mismatch rdat test %0d beat %0d: got %h expected %h", t, beat, got, want);
			note_error(t);
		end
	endtask

	task automatic check_last(input int t, input int beat, input logic got, input logic want);
		checks++;
		if (got !== want) begin
			$display("mismatch rdat_last test %0d beat %0d: got %h expected %h",
				t, beat, got, want);
			note_error(t);
		end
	endtask

	task automatic check_done(input int t, input axi_burst_pkg::burst_op_e got_op,
			input logic [`AXI_ID_W-1:0] got_id, input axi_burst_pkg::axi_resp_e got_resp,
			input axi_burst_pkg::completion_t want);
		checks++;
		if (got_op !== want.op) begin
			$display("mismatch done_op test %0d: got %h expected %h", t, got_op, want.op);
			note_error(t);
		end
		if (got_id !== want.id) begin
			$display("mismatch done_id test %0d: got %h expected %h", t, got_id, want.id);
			note_error(t);
		end
		if (got_resp !== want.resp) begin
			$display("mismatch done_resp test %0d: got %h expected %h", t, got_resp, want.resp);
			note_error(t);
		end
	endtask

	task automatic run_write(input int t, input logic [`AXI_ADDR_W-1:0] addr,
			input logic [`AXI_ID_W-1:0] id, input logic [`AXI_LEN_W-1:0] len,
			input axi_burst_pkg::axi_resp_e resp);
		axi_burst_pkg::completion_t c;
		int b;
		int byte_addr;
		logic got;
		c.op = axi_burst_pkg::OP_WRITE;
		c.id = id;
		c.resp = resp;
		wr_cmd_valid = 1'b1;
		wr_cmd_addr = addr;
		wr_cmd_id = id;
		wr_cmd_len = len;
		got = 1'b0;
		while (!got) begin
			@(negedge clk);
			got = wr_cmd_ready;
			@(posedge clk);
			#DRIVE_DLY;
		end
		exp_q.push_back(c);
		exp_test_q.push_back(t);
		wr_cmd_valid = 1'b0;
		for (b = 0; b <= int'(len); b++) begin
			rng_data = xorshift(rng_data);
			wdat_valid = 1'b1;
			wdat = rng_data;
			got = 1'b0;
			while (!got) begin
				@(negedge clk);
				got = wdat_ready;
				@(posedge clk);
				#DRIVE_DLY;
			end
			// Beats past the end of memory are dropped by the target
			byte_addr = int'(addr) + 4 * b;
			if (byte_addr < MEM_BYTES)
				model[byte_addr / 4] = wdat;
		end
		wdat_valid = 1'b0;
	endtask

	task automatic run_read(input int t, input logic [`AXI_ADDR_W-1:0] addr,
			input logic [`AXI_ID_W-1:0] id, input logic [`AXI_LEN_W-1:0] len,
			input axi_burst_pkg::axi_resp_e resp);
		axi_burst_pkg::completion_t c;
		logic [`AXI_DATA_W-1:0] want;
		int b;
		int byte_addr;
		logic got;
		c.op = axi_burst_pkg::OP_READ;
		c.id = id;
		c.resp = resp;
		rd_cmd_valid = 1'b1;
		rd_cmd_addr = addr;
		rd_cmd_id = id;
		rd_cmd_len = len;
		got = 1'b0;
		while (!got) begin
			@(negedge clk);
			got = rd_cmd_ready;
			@(posedge clk);
			#DRIVE_DLY;
		end
		exp_q.push_back(c);
		exp_test_q.push_back(t);
		rd_cmd_valid = 1'b0;
		b = 0;
		while (b <= int'(len)) begin
			@(negedge clk);
			if (rdat_valid && rdat_ready) begin
				byte_addr = int'(addr) + 4 * b;
				want = (byte_addr < MEM_BYTES) ? model[byte_addr / 4] : '0;
				check_word(t, b, rdat, want);
				check_last(t, b, rdat_last, b == int'(len));
				b++;
			end
		end
		@(posedge clk);
		#DRIVE_DLY;
	endtask

	// Random stall pattern for read data and completions
	initial begin
		rdat_ready = 1'b0;
		done_ready = 1'b0;
		rng_bp = 32'd68;
		wait (rstn === 1'b1);
		forever begin
			@(posedge clk);
			#DRIVE_DLY;
			rng_bp = xorshift(rng_bp);
			rdat_ready = (rng_bp[1:0] != 2'b00);
			done_ready = (rng_bp[4:3] != 2'b00);
		end
	end

	// Completions may come in any order, so each one is matched to the
	// oldest outstanding command of the same kind
	initial begin
		int i;
		int found;
		done_seen = 0;
		forever begin
			@(negedge clk);
			if (rstn && done_valid && done_ready) begin
				found = -1;
				for (i = 0; i < exp_q.size(); i++)
					if (found < 0 && exp_q[i].op == done_op)
						found = i;
				if (found < 0) begin
					$display("unexpected completion with op %h id %h, no such command is open",
						done_op, done_id);
					errors++;
				end else begin
					check_done(exp_test_q[found], done_op, done_id, done_resp, exp_q[found]);
					$display("test %0d %s id %h resp %h: %0d errors", exp_test_q[found],
						(done_op == axi_burst_pkg::OP_WRITE) ? "write" : "read",
						done_id, done_resp, test_err[exp_test_q[found]]);
					exp_q.delete(found);
					exp_test_q.delete(found);
					done_seen++;
				end
			end
		end
	end

	initial begin
		cycles = 0;
		wait (cycle_limit > 0);
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the tests did not finish within %0d cycles", cycle_limit);
		$display("TB FAILED");
		$finish;
	end

	initial begin
		int ntests;
		int beats;
		int k;
		rstn = 1'b0;
		wr_cmd_valid = 1'b0;
		wr_cmd_addr = '0;
		wr_cmd_id = '0;
		wr_cmd_len = '0;
		wdat_valid = 1'b0;
		wdat = '0;
		rd_cmd_valid = 1'b0;
		rd_cmd_addr = '0;
		rd_cmd_id = '0;
		rd_cmd_len = '0;
		rng_data = 32'd68;
		errors = 0;
		checks = 0;
		cycle_limit = 0;
		for (k = 0; k < 5 * MAX_TESTS; k++)
			test_vec[k] = 16'hffff;
		$readmemh("verif/axi_burst_tests.txt", test_vec);
		ntests = 0;
		beats = 0;
		while (ntests < MAX_TESTS && test_vec[5 * ntests] != 16'hffff) begin
			beats += int'(test_vec[5 * ntests + 3]) + 1;
			ntests++;
		end
		cycle_limit = 200 + 12 * beats + 30 * ntests;
		repeat (2) @(posedge clk);
		#DRIVE_DLY;
		rstn = 1'b1;
		for (k = 0; k < ntests; k++) begin
			if (test_vec[5 * k] == 16'h0)
				run_write(k, test_vec[5 * k + 2], test_vec[5 * k + 1][3:0],
					test_vec[5 * k + 3][3:0],
					axi_burst_pkg::axi_resp_e'(test_vec[5 * k + 4][1:0]));
			else if (test_vec[5 * k] == 16'h1)
				run_read(k, test_vec[5 * k + 2], test_vec[5 * k + 1][3:0],
					test_vec[5 * k + 3][3:0],
					axi_burst_pkg::axi_resp_e'(test_vec[5 * k + 4][1:0]));
			else begin
				$display("test %0d has an unknown opcode in the tests file", k);
				note_error(k);
				done_seen++;
			end
		end
		while (done_seen < ntests)
			@(negedge clk);
		// A few more cycles so that a duplicate completion still shows up
		repeat (10) @(negedge clk);
		$display("%0d tests, %0d checks, %0d errors", ntests, checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* verif/axi_burst_tests.txt */
// Columns in hex: op (0 write, 1 read), id, byte address, len (beats minus one),
// expected response (0 OKAY, 2 SLVERR). Memory ends at byte address 0400
0 1 0000 3 0
1 2 0000 3 0
0 3 0100 f 0
1 4 0100 f 0
1 5 0108 2 0
0 6 0040 0 0
1 7 0040 0 0
0 8 03f8 3 2 // crosses the end of memory
1 9 03f8 3 2
1 a 0000 3 0 // words 0 to 3 untouched by the dropped beats
0 b 0200 7 0
1 c 0200 7 0
1 d 03fc 1 2
0 e 03e0 7 0
1 f 03e0 7 0
0 1 0400 1 2 // wholly out of range
1 2 0400 1 2
0 3 0020 f 0
0 4 0010 3 0
1 5 0000 f 0
1 6 0020 f 0
1 7 03f0 f 2

/* filelist.f */
+incdir+verilog
verilog/axi_burst_pkg.sv
verilog/axi4_bus.sv
verilog/axi_write_engine.sv
verilog/axi_read_engine.sv
verilog/completion_merge.sv
verilog/axi4_mem_target.sv
verilog/axi_burst_top.sv
verif/axi_burst_asserts.sv
verif/axi_burst_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run the testbench, pass only if the pass message is printed
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module axi_burst_tb -f filelist.f || exit 1
out=$(./obj_dir/Vaxi_burst_tb 2>&1)
echo "$out"
echo "$out" | grep -qx "TB PASSED" && exit 0 || exit 1
